/* Makefile */
# Verilator build and run of the execute stage testbench.

VERILATOR ?= verilator
TOP       ?= exu_tb
LOG       ?= sim.log
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_csr_file.sv
verilog/exu_stage.sv
verilog/exu_data_mem.sv
verilog/exu_top.sv
verif/exu_tb.sv

/* verif/exu_golden.txt */
# name pc src1 src2 base imm op alu_op sys_op csr_addr rd rd_we stall, then expected
# rd rd_we rd_data npc ebreak; all values after the name are hex
add 0 5 3 0 0 0 0 0 0 1 1 0 1 1 8 4 0
sub 4 3 5 0 0 0 1 0 0 2 1 0 2 1 fffffffe 8 0
and 8 f0f0 ff00 0 0 0 2 0 0 3 1 0 3 1 f000 c 0
or c f0f0 0f0f 0 0 0 3 0 0 4 1 0 4 1 ffff 10 0
xor 10 ffff 0ff0 0 0 0 4 0 0 5 1 0 5 1 f00f 14 0
sll 14 1 24 0 0 0 5 0 0 6 1 0 6 1 10 18 0
srl 18 80000000 4 0 0 0 6 0 0 7 1 0 7 1 8000000 1c 0
sra 1c 80000000 4 0 0 0 7 0 0 8 1 0 8 1 f8000000 20 0
slt 20 ffffffff 1 0 0 0 8 0 0 9 1 0 9 1 1 24 0
sltu 24 ffffffff 1 0 0 0 9 0 0 a 1 0 a 1 0 28 0
sle 28 7 7 0 0 0 a 0 0 b 1 0 b 1 1 2c 0
sleu 2c 8 7 0 0 0 b 0 0 c 1 0 c 1 0 30 0
add_stall 30 7fffffff 1 0 0 0 0 0 0 d 1 5 d 1 80000000 34 0
beq_taken 100 9 9 100 40 3 1 0 0 0 0 0 0 0 0 140 0
beq_not 104 9 8 104 40 3 1 0 0 0 0 0 0 0 1 108 0
bne_taken 108 9 8 108 fffffff8 3 4 0 0 0 0 0 0 0 1 100 0
blt_taken 10c ffffffff 2 10c 20 3 8 0 0 0 0 0 0 0 1 12c 0
bge_not 110 2 ffffffff 110 20 3 a 0 0 0 0 0 0 0 0 114 0
bge_taken 114 ffffffff 2 114 30 3 a 0 0 0 0 0 0 0 1 144 0
bltu_not 118 ffffffff 2 118 20 3 9 0 0 0 0 0 0 0 0 11c 0
jal 200 0 0 200 80 4 0 0 0 1 1 0 1 1 204 280 0
jalr 204 0 0 1000 10 5 0 0 0 1 1 0 1 1 208 1010 0
store 300 0 deadbeef 0 40 2 0 0 0 0 0 0 0 0 deadbeef 304 0
load 304 0 0 20 20 1 0 0 0 5 1 0 5 1 deadbeef 308 0
load_wrap 308 0 0 400 40 1 0 0 0 5 1 0 5 1 deadbeef 30c 0
load_zero 30c 0 0 0 80 1 0 0 0 5 1 0 5 1 0 310 0
store_stall 310 0 12345678 0 44 2 0 0 0 0 0 3 0 0 12345678 314 0
load_stall 314 0 0 44 0 1 0 0 0 6 1 2 6 1 12345678 318 0
csrrw_mtvec 400 200 0 0 0 6 0 1 305 3 1 0 3 1 100 404 0
csrrs_mtvec 404 c 0 0 0 6 0 2 305 3 1 0 3 1 200 408 0
csrrc_mtvec 408 204 0 0 0 6 0 3 305 3 1 0 3 1 20c 40c 0
read_mtvec 40c 0 0 0 0 6 0 2 305 3 1 0 3 1 8 410 0
csrrw_stall 410 400 0 0 0 6 0 1 305 3 1 4 3 1 8 414 0
mtvec_after 414 0 0 0 0 6 0 2 305 3 1 0 3 1 400 418 0
unknown_write 418 ffffffff 0 0 0 6 0 1 7c0 4 1 0 4 1 0 41c 0
unknown_read 41c 0 0 0 0 6 0 2 7c0 4 1 0 4 1 0 420 0
ecall 500 0 0 0 0 6 0 4 0 0 0 0 0 0 0 400 0
read_mepc 504 0 0 0 0 6 0 2 341 6 1 0 6 1 500 508 0
read_mcause 508 0 0 0 0 6 0 2 342 6 1 0 6 1 b 50c 0
set_mstatus 50c 80 0 0 0 6 0 1 300 7 1 0 7 1 0 510 0
mret 600 0 0 0 0 6 0 6 0 0 0 2 0 0 0 500 0
read_mstatus 604 0 0 0 0 6 0 2 300 7 1 0 7 1 88 608 0
clear_mstatus 608 0 0 0 0 6 0 1 300 7 1 0 7 1 88 60c 0
mret_stall 700 0 0 0 0 6 0 6 0 0 0 3 0 0 0 500 0
mstatus_once 704 0 0 0 0 6 0 2 300 7 1 0 7 1 80 708 0
ebreak 800 0 0 0 0 6 0 5 0 0 0 0 0 0 0 804 1

/* verif/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_tb;

  localparam int TIMEOUT_CYCLES = 50;

  logic              clk;
  logic              rst;
  logic              in_valid_i;
  exu_pkg::exu_req_t in_req_i;
  logic              in_ready_o;
  logic              wb_valid_o;
  exu_pkg::exu_wb_t  wb_o;
  logic              wb_ready_i;

  int tests_run;
  int tests_failed;
  int errors;
  bit timed_out;

  exu_top #(
    .MEM_WORDS   (256),
    .MTVEC_RESET (32'h100)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_req_i   (in_req_i),
    .in_ready_o (in_ready_o),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ========================================
  // one instruction through the stage
  // ========================================

  task automatic run_instr(input string name, input exu_pkg::exu_req_t req,
                           input int stall, input exu_pkg::exu_wb_t exp);
    int               waited;
    int               errors_before;
    exu_pkg::exu_wb_t held;
    errors_before = errors;
    tests_run++;
    waited = 0;
    @(negedge clk);
    while (!in_ready_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready_o) begin
      $display("test %s: stage never became ready to accept within %0d cycles",
               name, TIMEOUT_CYCLES);
      timed_out = 1'b1;
      errors++;
    end else begin
      @(posedge clk);
      in_valid_i <= 1'b1;
      in_req_i   <= req;
      @(posedge clk);
      in_valid_i <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (!wb_valid_o && waited < TIMEOUT_CYCLES) begin
        @(negedge clk);
        waited++;
      end
      if (!wb_valid_o) begin
        $display("test %s: no writeback record appeared within %0d cycles",
                 name, TIMEOUT_CYCLES);
        timed_out = 1'b1;
        errors++;
      end else begin
        held = wb_o;
        // downstream holds off, so the record must sit still.
        repeat (stall) begin
          @(negedge clk);
          assert (wb_valid_o && !in_ready_o && wb_o == held) else begin
            $display("FAILED at %0t: %s record or handshake moved under back-pressure",
                     $time, name);
            errors++;
          end
        end
        @(posedge clk);
        wb_ready_i <= 1'b1;
        @(posedge clk);
        wb_ready_i <= 1'b0;
        assert (held == exp) else begin
          $display("FAILED at %0t: %s got rd=%0d we=%0b data=%h npc=%h ebreak=%0b",
                   $time, name, held.rd, held.rd_we, held.rd_data, held.npc, held.ebreak);
          $display("FAILED at %0t: %s exp rd=%0d we=%0b data=%h npc=%h ebreak=%0b",
                   $time, name, exp.rd, exp.rd_we, exp.rd_data, exp.npc, exp.ebreak);
          errors++;
        end
      end
    end
    if (errors != errors_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int                fd;
    int                fields;
    string             line;
    string             name;
    logic [31:0]       f_pc, f_src1, f_src2, f_base, f_imm;
    logic [31:0]       f_op, f_alu, f_sys, f_csr, f_rd, f_we, f_stall;
    logic [31:0]       e_rd, e_we, e_data, e_npc, e_brk;
    exu_pkg::exu_req_t req;
    exu_pkg::exu_wb_t  exp;

    rst          = 1'b1;
    in_valid_i   = 1'b0;
    in_req_i     = '0;
    wb_ready_i   = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    timed_out    = 1'b0;

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    tests_run++;
    assert (in_ready_o && !wb_valid_o) else begin
      $display("FAILED at %0t: reset state has in_ready=%0b wb_valid=%0b",
               $time, in_ready_o, wb_valid_o);
      errors++;
      tests_failed++;
    end
    $display("test reset: %s", (errors == 0) ? "ok" : "failed");

    fd = $fopen("verif/exu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file verif/exu_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           name, f_pc, f_src1, f_src2, f_base, f_imm, f_op, f_alu, f_sys,
                           f_csr, f_rd, f_we, f_stall, e_rd, e_we, e_data, e_npc, e_brk);
          if (fields != 18) begin
            $display("golden line could not be parsed: %s", line);
            errors++;
          end else begin
            req.pc       = f_pc;
            req.src1     = f_src1;
            req.src2     = f_src2;
            req.base     = f_base;
            req.imm      = f_imm;
            req.op       = exu_pkg::exu_op_e'(f_op[2:0]);
            req.alu_op   = exu_pkg::alu_op_e'(f_alu[3:0]);
            req.sys_op   = exu_pkg::sys_op_e'(f_sys[2:0]);
            req.csr_addr = f_csr[11:0];
            req.rd       = f_rd[4:0];
            req.rd_we    = f_we[0];
            exp.rd       = e_rd[4:0];
            exp.rd_we    = e_we[0];
            exp.rd_data  = e_data;
            exp.npc      = e_npc;
            exp.ebreak   = e_brk[0];
            run_instr(name, req, int'(f_stall), exp);
          end
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_run > 1) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] a_i,
  input  logic [exu_pkg::XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e         op_i,
  output logic [exu_pkg::XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = (a_i == b_i);

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::ALU_ADD:  res_o = a_i + b_i;
      exu_pkg::ALU_SUB:  res_o = a_i - b_i;
      exu_pkg::ALU_AND:  res_o = a_i & b_i;
      exu_pkg::ALU_OR:   res_o = a_i | b_i;
      exu_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exu_pkg::ALU_SLL:  res_o = a_i << shamt;
      exu_pkg::ALU_SRL:  res_o = a_i >> shamt;
      exu_pkg::ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      // compares return a single set bit.
      exu_pkg::ALU_SLT:  res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
      exu_pkg::ALU_SLTU: res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
      exu_pkg::ALU_SLE:  res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_s | eq};
      exu_pkg::ALU_SLEU: res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_u | eq};
      default:           res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/exu_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_csr_file #(
  parameter logic [exu_pkg::XLEN-1:0] MTVEC_RESET = 32'h100
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [exu_pkg::CSR_ADDR_W-1:0] addr_i,
  input  logic                           we_i,
  input  logic [exu_pkg::XLEN-1:0]       wdata_i,
  input  logic                           trap_i,
  input  logic [exu_pkg::XLEN-1:0]       trap_pc_i,
  output logic [exu_pkg::XLEN-1:0]       rdata_o,
  output logic [exu_pkg::XLEN-1:0]       mepc_o,
  output logic [exu_pkg::XLEN-1:0]       mtvec_o
);

  logic [exu_pkg::XLEN-1:0] mstatus_q;
  logic [exu_pkg::XLEN-1:0] mtvec_q;
  logic [exu_pkg::XLEN-1:0] mepc_q;
  logic [exu_pkg::XLEN-1:0] mcause_q;

  // ========================================
  // read port
  // ========================================

  always_comb begin
    case (addr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus_q;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec_q;
      exu_pkg::CSR_MEPC:    rdata_o = mepc_q;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause_q;
      default:              rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

  // ========================================
  // write port
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (we_i) begin
        case (addr_i)
          exu_pkg::CSR_MSTATUS: mstatus_q <= wdata_i;
          exu_pkg::CSR_MTVEC:   mtvec_q   <= wdata_i;
          exu_pkg::CSR_MEPC:    mepc_q    <= wdata_i;
          exu_pkg::CSR_MCAUSE:  mcause_q  <= wdata_i;
          default: ;
        endcase
      end
      // the trap side-writes take priority over the regular port.
      if (trap_i) begin
        mepc_q   <= trap_pc_i;
        mcause_q <= exu_pkg::ECALL_CAUSE;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/exu_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_data_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  exu_pkg::apb_req_t apb_i,
  output exu_pkg::apb_rsp_t apb_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [exu_pkg::XLEN-1:0] mem [MEM_WORDS];
  logic [exu_pkg::XLEN-1:0] word_addr;
  logic [IDX_W-1:0]         idx;
  logic                     access;
  logic                     waited_q;

  // word index from the byte address, wrapped to the memory depth.
  assign word_addr = (apb_i.paddr >> 2) % MEM_WORDS;
  assign idx       = word_addr[IDX_W-1:0];
  assign access    = apb_i.psel && apb_i.penable;

  // pready rises only on the second access cycle to insert one wait state.
  always_ff @(posedge clk) begin
    if (rst) begin
      waited_q <= 1'b0;
    end else if (access && !waited_q) begin
      waited_q <= 1'b1;
    end else begin
      waited_q <= 1'b0;
    end
  end

  assign apb_o.pready = access && waited_q;
  assign apb_o.prdata = mem[idx];

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (apb_o.pready && apb_i.pwrite) begin
      mem[idx] <= apb_i.pwdata;
    end
  end

endmodule

`default_nettype wire

/* verilog/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;
  localparam int CSR_ADDR_W = 12;

  // ========================================
  // instruction classes and operations
  // ========================================

  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_SYSTEM
  } exu_op_e;

  // the compare ops double as branch conditions.
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLE,
    ALU_SLEU
  } alu_op_e;

  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET
  } sys_op_e;

  // ========================================
  // machine CSRs
  // ========================================

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] ECALL_CAUSE = 32'd11;

  // ========================================
  // records and bus
  // ========================================

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    logic [XLEN-1:0]       base;
    logic [XLEN-1:0]       imm;
    exu_op_e               op;
    alu_op_e               alu_op;
    sys_op_e               sys_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [4:0]            rd;
    logic                  rd_we;
  } exu_req_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_we;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] npc;
    logic            ebreak;
  } exu_wb_t;

  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] paddr;
    logic [XLEN-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/exu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid_i,
  input  exu_pkg::exu_req_t              in_req_i,
  output logic                           in_ready_o,
  output logic                           wb_valid_o,
  output exu_pkg::exu_wb_t               wb_o,
  input  logic                           wb_ready_i,
  output exu_pkg::apb_req_t              apb_o,
  input  exu_pkg::apb_rsp_t              apb_i,
  output logic [exu_pkg::XLEN-1:0]       alu_a_o,
  output logic [exu_pkg::XLEN-1:0]       alu_b_o,
  output exu_pkg::alu_op_e               alu_op_o,
  input  logic [exu_pkg::XLEN-1:0]       alu_res_i,
  output logic [exu_pkg::CSR_ADDR_W-1:0] csr_addr_o,
  output logic                           csr_we_o,
  output logic [exu_pkg::XLEN-1:0]       csr_wdata_o,
  output logic                           trap_o,
  output logic [exu_pkg::XLEN-1:0]       trap_pc_o,
  input  logic [exu_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [exu_pkg::XLEN-1:0]       mepc_i,
  input  logic [exu_pkg::XLEN-1:0]       mtvec_i
);

  typedef enum logic [2:0] {
    IDLE,
    EXEC,
    APB_SETUP,
    APB_ACCESS,
    RESULT
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  exu_pkg::exu_req_t        req_q;
  logic [exu_pkg::XLEN-1:0] load_data_q;
  logic [exu_pkg::XLEN-1:0] target;
  logic [exu_pkg::XLEN-1:0] pc_plus4;
  logic                     is_system;
  logic                     is_mem;
  logic                     is_csr_op;
  logic                     is_ecall;
  logic                     is_mret;
  logic                     branch_taken;
  logic                     wb_fire;

  assign in_ready_o = (state_q == IDLE);
  assign wb_valid_o = (state_q == RESULT);
  assign wb_fire    = wb_valid_o && wb_ready_i;

  assign is_system = (req_q.op == exu_pkg::OP_SYSTEM);
  assign is_mem    = (req_q.op == exu_pkg::OP_LOAD) || (req_q.op == exu_pkg::OP_STORE);
  assign is_csr_op = is_system && ((req_q.sys_op == exu_pkg::SYS_CSRRW) ||
                                   (req_q.sys_op == exu_pkg::SYS_CSRRS) ||
                                   (req_q.sys_op == exu_pkg::SYS_CSRRC));
  assign is_ecall  = is_system && (req_q.sys_op == exu_pkg::SYS_ECALL);
  assign is_mret   = is_system && (req_q.sys_op == exu_pkg::SYS_MRET);

  // branch, jump and memory address all come from base plus imm.
  assign target   = req_q.base + req_q.imm;
  assign pc_plus4 = req_q.pc + 32'd4;

  // ========================================
  // control FSM
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (in_valid_i) state_d = EXEC;
      EXEC:       state_d = is_mem ? APB_SETUP : RESULT;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: if (apb_i.pready) state_d = RESULT;
      RESULT:     if (wb_ready_i) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      req_q <= in_req_i;
    end
    if ((state_q == APB_ACCESS) && apb_i.pready) begin
      load_data_q <= apb_i.prdata;
    end
  end

  // ========================================
  // APB master and ALU operands
  // ========================================

  assign apb_o.psel    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
  assign apb_o.penable = (state_q == APB_ACCESS);
  assign apb_o.pwrite  = (req_q.op == exu_pkg::OP_STORE);
  assign apb_o.paddr   = target;
  assign apb_o.pwdata  = req_q.src2;

  assign alu_a_o  = req_q.src1;
  assign alu_b_o  = req_q.src2;
  assign alu_op_o = req_q.alu_op;

  // ========================================
  // CSR read-modify-write
  // ========================================

  // writes land on the downstream transfer so a stalled record commits once.
  assign csr_we_o  = wb_fire && (is_csr_op || is_ecall || is_mret);
  assign trap_o    = wb_fire && is_ecall;
  assign trap_pc_o = req_q.pc;

  always_comb begin
    if (is_ecall) begin
      csr_addr_o = exu_pkg::CSR_MCAUSE;
    end else if (is_mret) begin
      csr_addr_o = exu_pkg::CSR_MSTATUS;
    end else begin
      csr_addr_o = req_q.csr_addr;
    end
  end

  always_comb begin
    case (req_q.sys_op)
      exu_pkg::SYS_CSRRW: csr_wdata_o = req_q.src1;
      exu_pkg::SYS_CSRRS: csr_wdata_o = csr_rdata_i | req_q.src1;
      exu_pkg::SYS_CSRRC: csr_wdata_o = csr_rdata_i & ~req_q.src1;
      exu_pkg::SYS_ECALL: csr_wdata_o = exu_pkg::ECALL_CAUSE;
      // MPIE moves back into MIE and MPIE is set again.
      exu_pkg::SYS_MRET:  csr_wdata_o = {csr_rdata_i[31:8], 1'b1, csr_rdata_i[6:4],
                                         csr_rdata_i[7], csr_rdata_i[2:0]};
      default:            csr_wdata_o = csr_rdata_i;
    endcase
  end

  // ========================================
  // writeback record
  // ========================================

  // BEQ runs as SUB, every other condition is a nonzero compare.
  assign branch_taken = (req_q.alu_op == exu_pkg::ALU_SUB) ? (alu_res_i == '0)
                                                           : (alu_res_i != '0);

  always_comb begin
    wb_o.rd     = req_q.rd;
    wb_o.rd_we  = req_q.rd_we;
    wb_o.ebreak = is_system && (req_q.sys_op == exu_pkg::SYS_EBREAK);

    case (req_q.op)
      exu_pkg::OP_LOAD:                  wb_o.rd_data = load_data_q;
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: wb_o.rd_data = pc_plus4;
      exu_pkg::OP_SYSTEM:                wb_o.rd_data = is_csr_op ? csr_rdata_i : alu_res_i;
      default:                           wb_o.rd_data = alu_res_i;
    endcase

    wb_o.npc = pc_plus4;
    case (req_q.op)
      exu_pkg::OP_BRANCH: begin
        if (branch_taken) begin
          wb_o.npc = target;
        end
      end
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: wb_o.npc = target;
      exu_pkg::OP_SYSTEM: begin
        if (is_ecall) begin
          wb_o.npc = mtvec_i;
        end else if (is_mret) begin
          wb_o.npc = mepc_i;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_top #(
  parameter int                       MEM_WORDS   = 256,
  parameter logic [exu_pkg::XLEN-1:0] MTVEC_RESET = 32'h100
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  input  exu_pkg::exu_req_t in_req_i,
  output logic              in_ready_o,
  output logic              wb_valid_o,
  output exu_pkg::exu_wb_t  wb_o,
  input  logic              wb_ready_i
);

  exu_pkg::apb_req_t              apb_req;
  exu_pkg::apb_rsp_t              apb_rsp;
  logic [exu_pkg::XLEN-1:0]       alu_a;
  logic [exu_pkg::XLEN-1:0]       alu_b;
  exu_pkg::alu_op_e               alu_op;
  logic [exu_pkg::XLEN-1:0]       alu_res;
  logic [exu_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic                           csr_we;
  logic [exu_pkg::XLEN-1:0]       csr_wdata;
  logic                           trap;
  logic [exu_pkg::XLEN-1:0]       trap_pc;
  logic [exu_pkg::XLEN-1:0]       csr_rdata;
  logic [exu_pkg::XLEN-1:0]       mepc;
  logic [exu_pkg::XLEN-1:0]       mtvec;

  exu_stage u_stage (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_req_i    (in_req_i),
    .in_ready_o  (in_ready_o),
    .wb_valid_o  (wb_valid_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i),
    .apb_o       (apb_req),
    .apb_i       (apb_rsp),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .alu_op_o    (alu_op),
    .alu_res_i   (alu_res),
    .csr_addr_o  (csr_addr),
    .csr_we_o    (csr_we),
    .csr_wdata_o (csr_wdata),
    .trap_o      (trap),
    .trap_pc_o   (trap_pc),
    .csr_rdata_i (csr_rdata),
    .mepc_i      (mepc),
    .mtvec_i     (mtvec)
  );

  exu_alu u_alu (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .op_i  (alu_op),
    .res_o (alu_res)
  );

  exu_csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr_file (
    .clk       (clk),
    .rst       (rst),
    .addr_i    (csr_addr),
    .we_i      (csr_we),
    .wdata_i   (csr_wdata),
    .trap_i    (trap),
    .trap_pc_i (trap_pc),
    .rdata_o   (csr_rdata),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

  exu_data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_mem (
    .clk   (clk),
    .rst   (rst),
    .apb_i (apb_req),
    .apb_o (apb_rsp)
  );

endmodule

`default_nettype wire
